// ==== compile.f ====
+incdir+hw
hw/rdma_pkg.sv
hw/sq_flow_ctrl.sv
hw/tx_req_engine.sv
hw/rx_ack_checker.sv
hw/rdma_stack_top.sv
tb/rdma_stack_tb.sv

// ==== hw/rdma_cfg.svh ====
// Widths and credit limit; RDMA_OUTS_BITS must hold RDMA_MAX_OUTSTANDING, and QP tables have 2**RDMA_QPN_BITS entries
`ifndef RDMA_CFG_SVH
`define RDMA_CFG_SVH

// Queue pair number and sequence number widths
`define RDMA_QPN_BITS 4
`define RDMA_PSN_BITS 8

// Work request fields
`define RDMA_VADDR_BITS 32
`define RDMA_LEN_BITS 16

// XOR checksum carried on acknowledgement words
`define RDMA_CSUM_BITS 8

// Statistics counters
`define RDMA_CNT_BITS 32

// Outstanding request credit
`define RDMA_MAX_OUTSTANDING 4
`define RDMA_OUTS_BITS 3

`endif

// ==== hw/rdma_pkg.sv ====
// Shared types only; opcode encodings are fixed at 2 bits and used unchanged on the transmit header
package rdma_pkg;

  // Work request opcodes
  typedef enum logic [1:0] {
    RDMA_OP_READ  = 2'd0,
    RDMA_OP_WRITE = 2'd1,
    RDMA_OP_SEND  = 2'd2
  } rdma_op_t;

  // Acknowledgement checker stages
  // IDLE takes a word, CHECK forms the verdict, DONE applies it
  typedef enum logic [1:0] {
    RX_IDLE  = 2'd0,
    RX_CHECK = 2'd1,
    RX_DONE  = 2'd2
  } rx_state_t;

endpackage

// ==== hw/rdma_stack_top.sv ====
// Send-queue subsystem top; no payload movement, single-beat headers, acks carry only QPN, PSN and an XOR checksum
`timescale 1ns/1ps

`include "rdma_cfg.svh"

module rdma_stack_top (
  input  logic                        nclk,
  input  logic                        nresetn,

  // Send queue
  input  logic                        sq_valid,
  output logic                        sq_ready,
  input  rdma_pkg::rdma_op_t          sq_op,
  input  logic [`RDMA_QPN_BITS-1:0]   sq_qpn,
  input  logic [`RDMA_VADDR_BITS-1:0] sq_vaddr,
  input  logic [`RDMA_LEN_BITS-1:0]   sq_len,

  // Transmit header
  output logic                        tx_valid,
  input  logic                        tx_ready,
  output rdma_pkg::rdma_op_t          tx_op,
  output logic [`RDMA_QPN_BITS-1:0]   tx_qpn,
  output logic [`RDMA_PSN_BITS-1:0]   tx_psn,
  output logic [`RDMA_VADDR_BITS-1:0] tx_vaddr,
  output logic [`RDMA_LEN_BITS-1:0]   tx_len,

  // Acknowledgements
  input  logic                        rx_valid,
  output logic                        rx_ready,
  input  logic [`RDMA_QPN_BITS-1:0]   rx_qpn,
  input  logic [`RDMA_PSN_BITS-1:0]   rx_psn,
  input  logic [`RDMA_CSUM_BITS-1:0]  rx_csum,

  // Statistics
  output logic [`RDMA_OUTS_BITS-1:0]  outstanding_count,
  output logic [`RDMA_CNT_BITS-1:0]   ack_count,
  output logic [`RDMA_CNT_BITS-1:0]   csum_drop_count,
  output logic [`RDMA_CNT_BITS-1:0]   psn_drop_count
);

  logic eng_valid;
  logic eng_ready;
  logic ack_pulse;

  // Credit gate
  sq_flow_ctrl flow_ctrl_i (
    .nclk              (nclk),
    .nresetn           (nresetn),
    .sq_valid          (sq_valid),
    .sq_ready          (sq_ready),
    .eng_valid         (eng_valid),
    .eng_ready         (eng_ready),
    .ack_pulse         (ack_pulse),
    .outstanding_count (outstanding_count),
    .ack_count         (ack_count)
  );

  // PSN stamping and transmit register
  tx_req_engine tx_engine_i (
    .nclk      (nclk),
    .nresetn   (nresetn),
    .eng_valid (eng_valid),
    .eng_ready (eng_ready),
    .sq_op     (sq_op),
    .sq_qpn    (sq_qpn),
    .sq_vaddr  (sq_vaddr),
    .sq_len    (sq_len),
    .tx_valid  (tx_valid),
    .tx_ready  (tx_ready),
    .tx_op     (tx_op),
    .tx_qpn    (tx_qpn),
    .tx_psn    (tx_psn),
    .tx_vaddr  (tx_vaddr),
    .tx_len    (tx_len)
  );

  // Acknowledgement validation
  rx_ack_checker rx_checker_i (
    .nclk            (nclk),
    .nresetn         (nresetn),
    .rx_valid        (rx_valid),
    .rx_ready        (rx_ready),
    .rx_qpn          (rx_qpn),
    .rx_psn          (rx_psn),
    .rx_csum         (rx_csum),
    .ack_pulse       (ack_pulse),
    .csum_drop_count (csum_drop_count),
    .psn_drop_count  (psn_drop_count)
  );

endmodule

// ==== hw/rx_ack_checker.sv ====
// One acknowledgement in flight at a time; a checksum failure hides any PSN error, and NAKs are not recognized
`timescale 1ns/1ps

`include "rdma_cfg.svh"

module rx_ack_checker (
  input  logic                       nclk,
  input  logic                       nresetn,

  // Acknowledgement words from the network side
  input  logic                       rx_valid,
  output logic                       rx_ready,
  input  logic [`RDMA_QPN_BITS-1:0]  rx_qpn,
  input  logic [`RDMA_PSN_BITS-1:0]  rx_psn,
  input  logic [`RDMA_CSUM_BITS-1:0] rx_csum,

  // One pulse per good word, returns a credit
  output logic                       ack_pulse,

  output logic [`RDMA_CNT_BITS-1:0]  csum_drop_count,
  output logic [`RDMA_CNT_BITS-1:0]  psn_drop_count
);

  import rdma_pkg::*;

  localparam int QP_COUNT = 1 << `RDMA_QPN_BITS;

  rx_state_t state;

  // Expected acknowledgement PSN per queue pair
  logic [`RDMA_PSN_BITS-1:0] exp_table [QP_COUNT];

  // Captured word
  logic [`RDMA_QPN_BITS-1:0]  cap_qpn;
  logic [`RDMA_PSN_BITS-1:0]  cap_psn;
  logic [`RDMA_CSUM_BITS-1:0] cap_csum;

  // Verdict formed in RX_CHECK, applied in RX_DONE
  logic csum_bad;
  logic psn_bad;

  logic [`RDMA_CSUM_BITS-1:0] csum_calc;

  assign rx_ready  = (state == RX_IDLE);
  assign csum_calc = `RDMA_CSUM_BITS'(cap_psn) ^ `RDMA_CSUM_BITS'(cap_qpn);

  always_ff @(posedge nclk) begin
    if (!nresetn) begin
      state           <= RX_IDLE;
      ack_pulse       <= 1'b0;
      csum_drop_count <= '0;
      psn_drop_count  <= '0;
      for (int i = 0; i < QP_COUNT; i++) begin
        exp_table[i] <= '0;
      end
    end else begin
      ack_pulse <= 1'b0;
      case (state)
        RX_IDLE: begin
          if (rx_valid) begin
            state <= RX_CHECK;
          end
        end
        RX_CHECK: begin
          state <= RX_DONE;
        end
        RX_DONE: begin
          // Exactly one outcome per word
          if (csum_bad) begin
            csum_drop_count <= csum_drop_count + 1'b1;
          end else if (psn_bad) begin
            psn_drop_count <= psn_drop_count + 1'b1;
          end else begin
            exp_table[cap_qpn] <= exp_table[cap_qpn] + 1'b1;
            ack_pulse          <= 1'b1;
          end
          state <= RX_IDLE;
        end
        default: begin
          state <= RX_IDLE;
        end
      endcase
    end
  end

  // Word capture and verdict registers
  always_ff @(posedge nclk) begin
    if (rx_valid && rx_ready) begin
      cap_qpn  <= rx_qpn;
      cap_psn  <= rx_psn;
      cap_csum <= rx_csum;
    end
    if (state == RX_CHECK) begin
      csum_bad <= (cap_csum != csum_calc);
      psn_bad  <= (cap_psn != exp_table[cap_qpn]);
    end
  end

endmodule

// ==== hw/sq_flow_ctrl.sv ====
// Credit gate for the send queue; an acknowledgement with nothing outstanding is counted but does not underflow the credit
`timescale 1ns/1ps

`include "rdma_cfg.svh"

module sq_flow_ctrl (
  input  logic                       nclk,
  input  logic                       nresetn,

  // Send queue handshake, outside side
  input  logic                       sq_valid,
  output logic                       sq_ready,

  // Handshake toward the transmit engine
  output logic                       eng_valid,
  input  logic                       eng_ready,

  // One cycle per good acknowledgement
  input  logic                       ack_pulse,

  output logic [`RDMA_OUTS_BITS-1:0] outstanding_count,
  output logic [`RDMA_CNT_BITS-1:0]  ack_count
);

  localparam logic [`RDMA_OUTS_BITS-1:0] MAX_OUTS = `RDMA_OUTS_BITS'(`RDMA_MAX_OUTSTANDING);

  logic                       credit_ok;
  logic                       sq_fire;
  logic [`RDMA_OUTS_BITS-1:0] outs_next;

  // Both sides of the handshake are masked at the limit
  assign credit_ok = (outstanding_count < MAX_OUTS);
  assign sq_ready  = eng_ready & credit_ok;
  assign eng_valid = sq_valid & credit_ok;

  assign sq_fire = sq_valid & sq_ready;

  // Request and ack on the same edge cancel out
  always_comb begin
    outs_next = outstanding_count;
    if (sq_fire && !ack_pulse) begin
      outs_next = outstanding_count + 1'b1;
    end else if (!sq_fire && ack_pulse && (outstanding_count != '0)) begin
      outs_next = outstanding_count - 1'b1;
    end
  end

  always_ff @(posedge nclk) begin
    if (!nresetn) begin
      outstanding_count <= '0;
    end else begin
      outstanding_count <= outs_next;
    end
  end

  // Total acknowledgements seen since reset
  always_ff @(posedge nclk) begin
    if (!nresetn) begin
      ack_count <= '0;
    end else if (ack_pulse) begin
      ack_count <= ack_count + 1'b1;
    end
  end

endmodule

// ==== hw/tx_req_engine.sv ====
// Single-entry transmit register; PSN counters wrap silently and there is no per-QP enable or reset
`timescale 1ns/1ps

`include "rdma_cfg.svh"

module tx_req_engine (
  input  logic                        nclk,
  input  logic                        nresetn,

  // Gated request from the credit gate, raw fields from the send queue
  input  logic                        eng_valid,
  output logic                        eng_ready,
  input  rdma_pkg::rdma_op_t          sq_op,
  input  logic [`RDMA_QPN_BITS-1:0]   sq_qpn,
  input  logic [`RDMA_VADDR_BITS-1:0] sq_vaddr,
  input  logic [`RDMA_LEN_BITS-1:0]   sq_len,

  // Transmit header word
  output logic                        tx_valid,
  input  logic                        tx_ready,
  output rdma_pkg::rdma_op_t          tx_op,
  output logic [`RDMA_QPN_BITS-1:0]   tx_qpn,
  output logic [`RDMA_PSN_BITS-1:0]   tx_psn,
  output logic [`RDMA_VADDR_BITS-1:0] tx_vaddr,
  output logic [`RDMA_LEN_BITS-1:0]   tx_len
);

  localparam int QP_COUNT = 1 << `RDMA_QPN_BITS;

  // Next PSN to stamp, one per queue pair
  logic [`RDMA_PSN_BITS-1:0] psn_table [QP_COUNT];

  logic                      accept;
  logic [`RDMA_PSN_BITS-1:0] cur_psn;

  // Register is free when empty or draining on this edge
  assign eng_ready = ~tx_valid | tx_ready;
  assign accept    = eng_valid & eng_ready;

  assign cur_psn = psn_table[sq_qpn];

  always_ff @(posedge nclk) begin
    if (!nresetn) begin
      for (int i = 0; i < QP_COUNT; i++) begin
        psn_table[i] <= '0;
      end
    end else if (accept) begin
      psn_table[sq_qpn] <= cur_psn + 1'b1;
    end
  end

  // Valid holds until the header is taken
  always_ff @(posedge nclk) begin
    if (!nresetn) begin
      tx_valid <= 1'b0;
    end else if (accept) begin
      tx_valid <= 1'b1;
    end else if (tx_ready) begin
      tx_valid <= 1'b0;
    end
  end

  // Header payload, loaded only on accept so it stays stable under back-pressure
  always_ff @(posedge nclk) begin
    if (accept) begin
      tx_op    <= sq_op;
      tx_qpn   <= sq_qpn;
      tx_psn   <= cur_psn;
      tx_vaddr <= sq_vaddr;
      tx_len   <= sq_len;
    end
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f compile.f --top-module rdma_stack_tb -o sim_rdma

# The simulator exits non-zero on failure; the log decides the verdict
./obj_dir/sim_rdma > sim.log 2>&1 || true
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
  exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
  echo "simulation ended without a verdict"
  exit 1
fi
exit 0

// ==== tb/rdma_cases.txt ====
# S op(R/W/S) qpn vaddr len | A qpn psn csum_good | H cycles | C outs acks csum_drops psn_drops
# All numbers hex
S W 1 00001000 0040
S R 2 00002000 0080
S S 1 00001040 0010
C 3 0 0 0
A 1 00 1
A 2 00 1
A 1 01 1
C 0 3 0 0
S S 3 00003000 0100
S W 3 00003100 0020
S R 5 00005000 0200
S W 3 00003120 0008
C 4 3 0 0
S S 5 00005200 0030
A 3 00 1
C 4 4 0 0
A 3 01 0
A 3 03 1
A 3 01 1
A 3 01 1
C 3 5 1 2
A 3 02 1
A 5 00 1
A 5 01 1
C 0 8 1 2
H 6
S W 7 00007000 0004
S R 7 00007010 0008
S S 2 00002100 000c
H 4
S W 7 00007020 0010
C 4 8 1 2
A 7 00 1
A 7 01 1
A 2 01 1
A 7 02 1
C 0 c 1 2

// ==== tb/rdma_stack_tb.sv ====
// Case-driven testbench; run from the project root so tb/rdma_cases.txt resolves, fields in hex
`timescale 1ns/1ps

`include "rdma_cfg.svh"

module rdma_stack_tb;

  import rdma_pkg::*;

  logic                        nclk;
  logic                        nresetn;
  logic                        sq_valid;
  logic                        sq_ready;
  rdma_op_t                    sq_op;
  logic [`RDMA_QPN_BITS-1:0]   sq_qpn;
  logic [`RDMA_VADDR_BITS-1:0] sq_vaddr;
  logic [`RDMA_LEN_BITS-1:0]   sq_len;
  logic                        tx_valid;
  logic                        tx_ready;
  rdma_op_t                    tx_op;
  logic [`RDMA_QPN_BITS-1:0]   tx_qpn;
  logic [`RDMA_PSN_BITS-1:0]   tx_psn;
  logic [`RDMA_VADDR_BITS-1:0] tx_vaddr;
  logic [`RDMA_LEN_BITS-1:0]   tx_len;
  logic                        rx_valid;
  logic                        rx_ready;
  logic [`RDMA_QPN_BITS-1:0]   rx_qpn;
  logic [`RDMA_PSN_BITS-1:0]   rx_psn;
  logic [`RDMA_CSUM_BITS-1:0]  rx_csum;
  logic [`RDMA_OUTS_BITS-1:0]  outstanding_count;
  logic [`RDMA_CNT_BITS-1:0]   ack_count;
  logic [`RDMA_CNT_BITS-1:0]   csum_drop_count;
  logic [`RDMA_CNT_BITS-1:0]   psn_drop_count;

  // Parsed cases
  byte         case_kind [$];
  logic [31:0] case_f0 [$];
  logic [31:0] case_f1 [$];
  logic [31:0] case_f2 [$];
  logic [31:0] case_f3 [$];

  // Reference model state
  logic [`RDMA_PSN_BITS-1:0] model_next_psn [16];
  logic [`RDMA_PSN_BITS-1:0] model_exp_psn [16];
  int                        model_outs;
  int                        model_acks;
  int                        model_csum_drops;
  int                        model_psn_drops;

  // Headers expected on the transmit port, in order
  logic [1:0]  exp_op_q [$];
  logic [3:0]  exp_qpn_q [$];
  logic [7:0]  exp_psn_q [$];
  logic [31:0] exp_vaddr_q [$];
  logic [15:0] exp_len_q [$];

  logic        sq_taken;
  int          hold_req;
  int          hold_left;
  int          cycle_cnt;
  int          cycle_limit;
  logic        prev_stall;
  logic [61:0] stall_word;

  rdma_stack_top dut_i (
    .nclk              (nclk),
    .nresetn           (nresetn),
    .sq_valid          (sq_valid),
    .sq_ready          (sq_ready),
    .sq_op             (sq_op),
    .sq_qpn            (sq_qpn),
    .sq_vaddr          (sq_vaddr),
    .sq_len            (sq_len),
    .tx_valid          (tx_valid),
    .tx_ready          (tx_ready),
    .tx_op             (tx_op),
    .tx_qpn            (tx_qpn),
    .tx_psn            (tx_psn),
    .tx_vaddr          (tx_vaddr),
    .tx_len            (tx_len),
    .rx_valid          (rx_valid),
    .rx_ready          (rx_ready),
    .rx_qpn            (rx_qpn),
    .rx_psn            (rx_psn),
    .rx_csum           (rx_csum),
    .outstanding_count (outstanding_count),
    .ack_count         (ack_count),
    .csum_drop_count   (csum_drop_count),
    .psn_drop_count    (psn_drop_count)
  );

  initial begin
    nclk = 1'b0;
    forever #10 nclk = ~nclk;
  end

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (exp == act) else begin
      $display("[FAIL] t=%0t %s expected %0h actual %0h", $time, name, exp, act);
      $display("=== FAIL ===");
      $fatal(1);
    end
  endtask

  task automatic fail_plain(input string what);
    $display("Error at t=%0t: %s", $time, what);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  function automatic rdma_op_t op_from_letter(input byte c);
    if (c == "R") begin
      return RDMA_OP_READ;
    end else if (c == "W") begin
      return RDMA_OP_WRITE;
    end
    return RDMA_OP_SEND;
  endfunction

  task automatic load_cases();
    int          fd;
    int          n;
    string       line;
    byte         kind;
    byte         opc;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;
    fd = $fopen("tb/rdma_cases.txt", "r");
    if (fd == 0) begin
      fail_plain("could not open tb/rdma_cases.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (line.len() < 2 || line[0] == "#") begin
        continue;
      end
      kind = line[0];
      a = '0;
      b = '0;
      c = '0;
      d = '0;
      if (kind == "S") begin
        n = $sscanf(line, "%c %c %h %h %h", kind, opc, b, c, d);
        a = 32'(op_from_letter(opc));
      end else if (kind == "A") begin
        n = $sscanf(line, "%c %h %h %h", kind, a, b, c);
      end else if (kind == "H") begin
        n = $sscanf(line, "%c %h", kind, a);
      end else if (kind == "C") begin
        n = $sscanf(line, "%c %h %h %h %h", kind, a, b, c, d);
      end else begin
        fail_plain("unknown case letter in the case file");
      end
      case_kind.push_back(kind);
      case_f0.push_back(a);
      case_f1.push_back(b);
      case_f2.push_back(c);
      case_f3.push_back(d);
    end
    $fclose(fd);
  endtask

  // Submit one request; at the credit limit it is left waiting after a check of sq_ready
  task automatic submit(input logic [31:0] op, input logic [31:0] qpn,
                        input logic [31:0] va, input logic [31:0] len);
    int gap;
    gap = int'($urandom % 3);
    @(posedge nclk);
    while (sq_valid) begin
      @(posedge nclk);
    end
    repeat (gap + 1) @(negedge nclk);
    sq_op    = rdma_op_t'(op[1:0]);
    sq_qpn   = qpn[3:0];
    sq_vaddr = va;
    sq_len   = len[15:0];
    sq_valid = 1'b1;
    if (model_outs >= `RDMA_MAX_OUTSTANDING) begin
      repeat (4) begin
        @(posedge nclk);
        check_val("sq_ready", 32'd0, 32'(sq_ready));
      end
    end else begin
      @(posedge nclk);
      while (sq_valid) begin
        @(posedge nclk);
      end
    end
  endtask

  task automatic send_ack(input logic [31:0] qpn, input logic [31:0] psn, input logic [31:0] good);
    logic [7:0] csum;
    csum = psn[7:0] ^ {4'b0000, qpn[3:0]};
    if (good == 32'd0) begin
      csum = ~csum;
    end
    @(negedge nclk);
    rx_qpn   = qpn[3:0];
    rx_psn   = psn[7:0];
    rx_csum  = csum;
    rx_valid = 1'b1;
    @(posedge nclk);
    while (!rx_ready) begin
      @(posedge nclk);
    end
    @(negedge nclk);
    rx_valid = 1'b0;
    if (good == 32'd0) begin
      model_csum_drops++;
    end else if (psn[7:0] != model_exp_psn[qpn[3:0]]) begin
      model_psn_drops++;
    end else begin
      model_exp_psn[qpn[3:0]] = model_exp_psn[qpn[3:0]] + 8'd1;
      model_acks++;
      if (model_outs > 0) begin
        model_outs--;
      end
    end
    // Checker busy in CHECK and DONE, free again two edges after the transfer
    repeat (2) begin
      @(posedge nclk);
      check_val("rx_ready", 32'd0, 32'(rx_ready));
    end
    @(posedge nclk);
    check_val("rx_ready", 32'd1, 32'(rx_ready));
  endtask

  task automatic check_counters(input logic [31:0] outs, input logic [31:0] acks,
                                input logic [31:0] cdrops, input logic [31:0] pdrops);
    @(posedge nclk);
    while (sq_valid) begin
      @(posedge nclk);
    end
    @(negedge nclk);
    check_val("model outstanding", outs, 32'(model_outs));
    check_val("outstanding_count", outs, 32'(outstanding_count));
    check_val("ack_count", acks, ack_count);
    check_val("model ack count", acks, 32'(model_acks));
    check_val("csum_drop_count", cdrops, csum_drop_count);
    check_val("model csum drops", cdrops, 32'(model_csum_drops));
    check_val("psn_drop_count", pdrops, psn_drop_count);
    check_val("model psn drops", pdrops, 32'(model_psn_drops));
  endtask

  // Model of send-queue acceptance and transmit checks
  always @(posedge nclk) begin
    if (nresetn) begin
      if (sq_valid && sq_ready) begin
        exp_op_q.push_back(sq_op);
        exp_qpn_q.push_back(sq_qpn);
        exp_psn_q.push_back(model_next_psn[sq_qpn]);
        exp_vaddr_q.push_back(sq_vaddr);
        exp_len_q.push_back(sq_len);
        model_next_psn[sq_qpn] = model_next_psn[sq_qpn] + 8'd1;
        model_outs++;
        sq_taken = 1'b1;
      end
      if (prev_stall && tx_valid) begin
        check_val("stalled tx header", 32'(stall_word[31:0]), tx_vaddr);
        check_val("stalled tx fields", 32'(stall_word[61:32]),
                  32'({tx_op, tx_qpn, tx_psn, tx_len}));
      end
      prev_stall = tx_valid && !tx_ready;
      stall_word = {tx_op, tx_qpn, tx_psn, tx_len, tx_vaddr};
      if (tx_valid && tx_ready) begin
        if (exp_op_q.size() == 0) begin
          fail_plain("a transmit header appeared that no accepted request explains");
        end
        check_val("tx_op", 32'(exp_op_q.pop_front()), 32'(tx_op));
        check_val("tx_qpn", 32'(exp_qpn_q.pop_front()), 32'(tx_qpn));
        check_val("tx_psn", 32'(exp_psn_q.pop_front()), 32'(tx_psn));
        check_val("tx_vaddr", exp_vaddr_q.pop_front(), tx_vaddr);
        check_val("tx_len", 32'(exp_len_q.pop_front()), 32'(tx_len));
      end
    end
  end

  // Drops sq_valid after a transfer and runs the tx_ready hold
  always @(negedge nclk) begin
    if (sq_taken) begin
      sq_valid = 1'b0;
      sq_taken = 1'b0;
    end
    if (hold_req > 0) begin
      tx_ready  = 1'b0;
      hold_left = hold_req;
      hold_req  = 0;
    end else if (hold_left > 0) begin
      hold_left--;
      tx_ready = (hold_left == 0);
    end
  end

  always @(posedge nclk) begin
    cycle_cnt++;
    if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
      $display("Timeout: the run exceeded %0d cycles without finishing", cycle_limit);
      $display("=== FAIL ===");
      $fatal(1);
    end
  end

  initial begin
    nresetn    = 1'b0;
    sq_valid   = 1'b0;
    sq_op      = RDMA_OP_READ;
    sq_qpn     = '0;
    sq_vaddr   = '0;
    sq_len     = '0;
    tx_ready   = 1'b1;
    rx_valid   = 1'b0;
    rx_qpn     = '0;
    rx_psn     = '0;
    rx_csum    = '0;
    sq_taken   = 1'b0;
    hold_req   = 0;
    hold_left  = 0;
    cycle_cnt  = 0;
    prev_stall = 1'b0;
    stall_word = '0;
    model_outs       = 0;
    model_acks       = 0;
    model_csum_drops = 0;
    model_psn_drops  = 0;
    for (int i = 0; i < 16; i++) begin
      model_next_psn[i] = '0;
      model_exp_psn[i]  = '0;
    end
    void'($urandom(78091));
    load_cases();
    cycle_limit = 40 * case_kind.size() + 100;
    repeat (2) @(posedge nclk);
    @(negedge nclk);
    nresetn = 1'b1;
    for (int i = 0; i < case_kind.size(); i++) begin
      if (case_kind[i] == "S") begin
        submit(case_f0[i], case_f1[i], case_f2[i], case_f3[i]);
      end else if (case_kind[i] == "A") begin
        send_ack(case_f0[i], case_f1[i], case_f2[i]);
      end else if (case_kind[i] == "H") begin
        @(posedge nclk);
        hold_req = int'(case_f0[i]);
      end else begin
        check_counters(case_f0[i], case_f1[i], case_f2[i], case_f3[i]);
      end
    end
    @(posedge nclk);
    while (tx_valid) begin
      @(posedge nclk);
    end
    @(negedge nclk);
    if (exp_op_q.size() != 0) begin
      fail_plain("accepted requests never appeared on the transmit port");
    end else begin
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule
